/* Makefile */
# Verilator build and run for the disk subsystem

TOP = diskSubsysTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log

/* verilog.f */
common/diskPkg.sv
src/regBusDecode.sv
drive/driveCtrl.sv
drive/driveStatus.sv
drive/diskDrive.sv
src/attnCollect.sv
src/diskSubsys.sv
verif/diskSubsys_props.sv
verif/diskSubsysTb.sv

/* verif/diskSubsysTb.sv */
// Disk subsystem testbench
// Directed tests over the four-phase host port, covering reset status,
// pack acknowledge, seek and attention, address errors, offset, last
// sector detection and refused register writes during a seek

`default_nettype none
`timescale 1ns/1ps

module diskSubsysTb;

   // About 80 host cycles of 3 clocks plus seek polling, with wide margin
   localparam int timeoutCycles = 3000;
   // Status reads allowed while waiting for DRY
   localparam int maxPolls      = 40;

   logic                               clk;
   logic                               rst;
   logic                               req;
   logic                               wr;
   logic [diskPkg::addrWidth-1:0]      addr;
   logic [diskPkg::dataWidth-1:0]      wdata;
   logic [diskPkg::numDrives-1:0]      cardDetect;
   logic [diskPkg::numDrives-1:0]      writeProtect;
   logic                               ack;
   logic [diskPkg::dataWidth-1:0]      rdata;
   logic                               attn;

   int errors;
   int checks;
   int cycles;

   diskSubsys dut (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .wr           (wr),
      .addr         (addr),
      .wdata        (wdata),
      .cardDetect   (cardDetect),
      .writeProtect (writeProtect),
      .ack          (ack),
      .rdata        (rdata),
      .attn         (attn)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= timeoutCycles)
      begin
         $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Host bus and checks
   //////////////////////////////////////////////////////////////////////

   function automatic logic [diskPkg::addrWidth-1:0] regAddr(input int drv,
                                                             input diskPkg::regSel_e sel);
      logic [diskPkg::driveSelBits-1:0] d;
      d = drv[diskPkg::driveSelBits-1:0];
      return {d, sel};
   endfunction

   // Reference status word of an idle drive, DPR set and PGM clear
   function automatic logic [15:0] expectedDs(input logic ata, input logic err,
                                              input logic mol, input logic lst,
                                              input logic vv, input logic om);
      logic [15:0] w;
      w = 16'h0000;
      w[diskPkg::dsAta] = ata;
      w[diskPkg::dsErr] = err;
      w[diskPkg::dsMol] = mol;
      w[diskPkg::dsLst] = lst;
      w[diskPkg::dsDpr] = 1'b1;
      w[diskPkg::dsDry] = 1'b1;
      w[diskPkg::dsVv]  = vv;
      w[diskPkg::dsOm]  = om;
      return w;
   endfunction

   task automatic checkValue(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL at %0d ns: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Full handshake, entered and left 5 ns after a rising edge
   task automatic busCycle(input logic isWr, input logic [diskPkg::addrWidth-1:0] a,
                           input logic [15:0] d, output logic [15:0] q);
      wr    = isWr;
      addr  = a;
      wdata = d;
      req   = 1'b1;
      do
      begin
         @(posedge clk);
         #5;
      end
      while (!ack);
      q   = rdata;
      req = 1'b0;
      do
      begin
         @(posedge clk);
         #5;
      end
      while (ack);
   endtask

   task automatic hostWrite(input int drv, input diskPkg::regSel_e sel, input logic [15:0] d);
      logic [15:0] unused;
      busCycle(1'b1, regAddr(drv, sel), d, unused);
   endtask

   task automatic hostRead(input int drv, input diskPkg::regSel_e sel, output logic [15:0] q);
      busCycle(1'b0, regAddr(drv, sel), 16'h0000, q);
   endtask

   task automatic readCheck(input string what, input int drv, input diskPkg::regSel_e sel,
                            input logic [15:0] exp);
      logic [15:0] q;
      hostRead(drv, sel, q);
      checkValue(what, q, exp);
   endtask

   // Poll DS until the drive reports DRY
   task automatic waitReady(input int drv);
      logic [15:0] ds;
      int          polls;
      polls = 0;
      hostRead(drv, diskPkg::regDs, ds);
      while (!ds[diskPkg::dsDry] && polls < maxPolls)
      begin
         polls++;
         hostRead(drv, diskPkg::regDs, ds);
      end
      checks++;
      assert (ds[diskPkg::dsDry])
      else
      begin
         errors++;
         $display("Drive %0d did not become ready after %0d status reads", drv, polls);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic testReset();
      for (int i = 0; i < diskPkg::numDrives; i++)
      begin
         readCheck("reset DS", i, diskPkg::regDs, expectedDs(0, 0, 1, 0, 0, 0));
         readCheck("reset ER1", i, diskPkg::regEr1, 16'h0000);
      end
      checkValue("reset attn", {15'd0, attn}, 16'h0000);
      // Write lock follows the protect input directly
      writeProtect[3] = 1'b1;
      readCheck("write lock DS", 3, diskPkg::regDs,
                expectedDs(0, 0, 1, 0, 0, 0) | (16'h0001 << diskPkg::dsWrl));
      writeProtect[3] = 1'b0;
   endtask

   task automatic testPackAck();
      hostWrite(0, diskPkg::regCs1, 16'(diskPkg::cmdPakAck));
      readCheck("pack ack DS", 0, diskPkg::regDs, expectedDs(0, 0, 1, 0, 1, 0));
      readCheck("pack ack CS1", 0, diskPkg::regCs1, 16'(diskPkg::cmdPakAck));
      // Pack pulled, MOL drops at once and VV on the next idle edge
      cardDetect[0] = 1'b0;
      readCheck("pack removed DS", 0, diskPkg::regDs, expectedDs(0, 0, 0, 0, 0, 0));
      cardDetect[0] = 1'b1;
      readCheck("pack back DS", 0, diskPkg::regDs, expectedDs(0, 0, 1, 0, 0, 0));
   endtask

   task automatic testSeekAttn();
      hostWrite(2, diskPkg::regDc, 16'd100);
      hostWrite(2, diskPkg::regCs1, 16'(diskPkg::cmdSeek));
      waitReady(2);
      readCheck("seek done DS", 2, diskPkg::regDs, expectedDs(1, 0, 1, 0, 0, 0));
      checkValue("seek attn", {15'd0, attn}, 16'h0001);
      readCheck("seek AS", 0, diskPkg::regAs, 16'h0004);
      hostWrite(0, diskPkg::regAs, 16'h0004);
      readCheck("cleared AS", 0, diskPkg::regAs, 16'h0000);
      checkValue("cleared attn", {15'd0, attn}, 16'h0000);
      readCheck("cleared DS", 2, diskPkg::regDs, expectedDs(0, 0, 1, 0, 0, 0));
      readCheck("drive 1 DS", 1, diskPkg::regDs, expectedDs(0, 0, 1, 0, 0, 0));
      readCheck("drive 3 DS", 3, diskPkg::regDs, expectedDs(0, 0, 1, 0, 0, 0));
      readCheck("drive 2 ER1", 2, diskPkg::regEr1, 16'h0000);
   endtask

   task automatic testBadCyl();
      hostWrite(1, diskPkg::regDc, 16'd900);
      hostWrite(1, diskPkg::regCs1, 16'(diskPkg::cmdSeek));
      waitReady(1);
      readCheck("bad cyl ER1", 1, diskPkg::regEr1, 16'h0001 << diskPkg::er1Iae);
      readCheck("bad cyl DS", 1, diskPkg::regDs, expectedDs(1, 1, 1, 0, 0, 0));
      checkValue("bad cyl attn", {15'd0, attn}, 16'h0001);
      hostWrite(1, diskPkg::regCs1, 16'(diskPkg::cmdDrvClr));
      waitReady(1);
      readCheck("drive clear ER1", 1, diskPkg::regEr1, 16'h0000);
      readCheck("drive clear DS", 1, diskPkg::regDs, expectedDs(0, 0, 1, 0, 0, 0));
      checkValue("drive clear attn", {15'd0, attn}, 16'h0000);
   endtask

   task automatic testOffsetLst();
      hostWrite(3, diskPkg::regCs1, 16'(diskPkg::cmdOffset));
      waitReady(3);
      readCheck("offset DS", 3, diskPkg::regDs, expectedDs(1, 0, 1, 0, 0, 1));
      hostWrite(0, diskPkg::regAs, 16'h0008);
      hostWrite(3, diskPkg::regCs1, 16'(diskPkg::cmdReturn));
      waitReady(3);
      readCheck("return DS", 3, diskPkg::regDs, expectedDs(1, 0, 1, 0, 0, 0));
      hostWrite(0, diskPkg::regAs, 16'h0008);
      // Track 18 in the upper byte, sector 19 in the lower
      hostWrite(3, diskPkg::regDa, 16'h1213);
      hostWrite(3, diskPkg::regDc, 16'd814);
      readCheck("last sector DS", 3, diskPkg::regDs, expectedDs(0, 0, 1, 1, 0, 0));
      hostWrite(3, diskPkg::regCs1, 16'(diskPkg::cmdPreset));
      readCheck("preset DS", 3, diskPkg::regDs, expectedDs(0, 0, 1, 0, 1, 0));
      readCheck("preset DA", 3, diskPkg::regDa, 16'h0000);
      readCheck("preset DC", 3, diskPkg::regDc, 16'h0000);
   endtask

   task automatic testRefused();
      // DA write inside the eight-cycle positioning delay
      hostWrite(0, diskPkg::regDa, 16'h0105);
      hostWrite(0, diskPkg::regDc, 16'd50);
      hostWrite(0, diskPkg::regCs1, 16'(diskPkg::cmdSeek));
      hostWrite(0, diskPkg::regDa, 16'h0203);
      // Still positioning, PIP up and DRY down
      readCheck("seeking DS", 0, diskPkg::regDs,
                (expectedDs(0, 1, 1, 0, 0, 0) & ~(16'h0001 << diskPkg::dsDry)) |
                (16'h0001 << diskPkg::dsPip));
      waitReady(0);
      readCheck("refused DA", 0, diskPkg::regDa, 16'h0105);
      readCheck("refused DA ER1", 0, diskPkg::regEr1, 16'h0001 << diskPkg::er1Rmr);
      hostWrite(0, diskPkg::regCs1, 16'(diskPkg::cmdDrvClr));
      waitReady(0);
      // Command inside the recalibrate delay
      hostWrite(0, diskPkg::regCs1, 16'(diskPkg::cmdRecal));
      hostWrite(0, diskPkg::regCs1, 16'(diskPkg::cmdOffset));
      waitReady(0);
      readCheck("recal DA", 0, diskPkg::regDa, 16'h0000);
      readCheck("refused cmd ER1", 0, diskPkg::regEr1, 16'h0001 << diskPkg::er1Rmr);
      readCheck("refused cmd DS", 0, diskPkg::regDs, expectedDs(1, 1, 1, 0, 0, 0));
      hostWrite(0, diskPkg::regCs1, 16'(diskPkg::cmdDrvClr));
      waitReady(0);
      checkValue("final attn", {15'd0, attn}, 16'h0000);
   endtask

   initial
   begin
      errors       = 0;
      checks       = 0;
      cycles       = 0;
      clk          = 1'b0;
      rst          = 1'b1;
      req          = 1'b0;
      wr           = 1'b0;
      addr         = '0;
      wdata        = '0;
      cardDetect   = '1;
      writeProtect = '0;
      repeat (16) @(posedge clk);
      #5;
      rst = 1'b0;

      testReset();
      testPackAck();
      testSeekAttn();
      testBadCyl();
      testOffsetLst();
      testRefused();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/diskSubsys_props.sv */
// Host handshake and drive strobe properties
// Bound into the subsystem top level

`default_nettype none
`timescale 1ns/1ps

module diskSubsys_props (
   input wire logic                          clk,
   input wire logic                          rst,
   input wire logic                          req,
   input wire logic                          ack,
   input wire logic [diskPkg::numDrives-1:0] wrStb
);

   // ack only answers a pending request
   ackNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
      else $error("ack rose without a pending req");

   // Four-phase, ack held until the host lets go
   ackHolds: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
      else $error("ack fell while req was still high");

   // One drive written per access, only in the cycle ack rises
   strobeOneHot: assert property (@(posedge clk) disable iff (rst)
                                  |wrStb |-> $onehot(wrStb) && $rose(ack))
      else $error("drive write strobe not one-hot or outside the ack rise");

endmodule

bind diskSubsys diskSubsys_props uProps (
   .clk   (clk),
   .rst   (rst),
   .req   (req),
   .ack   (ack),
   .wrStb (wrStb)
);

`default_nettype wire

/* src/diskSubsys.sv */
// Disk controller slice, top level
// Host port decoder, four emulated drives and the readback and
// attention collector

`default_nettype none
`timescale 1ns/1ps

module diskSubsys (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             req,
   input  wire logic                             wr,
   input  wire logic [diskPkg::addrWidth-1:0]    addr,
   input  wire logic [diskPkg::dataWidth-1:0]    wdata,
   input  wire logic [diskPkg::numDrives-1:0]    cardDetect,
   input  wire logic [diskPkg::numDrives-1:0]    writeProtect,
   output logic                                  ack,
   output logic [diskPkg::dataWidth-1:0]         rdata,
   output logic                                  attn
);

   // Decoder to drives
   logic [diskPkg::numDrives-1:0]    wrStb;
   logic [diskPkg::numDrives-1:0]    asClr;
   logic [diskPkg::driveSelBits-1:0] driveSel;
   logic [diskPkg::dataWidth-1:0]    wdataOut;
   logic [diskPkg::dataWidth-1:0]    rdCandidate;
   diskPkg::regSel_e                 regSel;

   // Drives to collector
   logic [diskPkg::numDrives-1:0]                        ataOut;
   logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] dsOut;
   logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] er1Out;
   logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] daOut;
   logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] dcOut;
   logic [diskPkg::numDrives-1:0][$bits(diskPkg::driveCmd_e)-1:0] fncOut;

   regBusDecode uDecode (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .wr          (wr),
      .addr        (addr),
      .wdata       (wdata),
      .rdCandidate (rdCandidate),
      .ack         (ack),
      .rdata       (rdata),
      .wrStb       (wrStb),
      .regSel      (regSel),
      .wdataOut    (wdataOut),
      .asClr       (asClr),
      .driveSel    (driveSel)
   );

   // One drive per select code
   for (genvar i = 0; i < diskPkg::numDrives; i++)
   begin : gDrive
      diskDrive uDrive (
         .clk          (clk),
         .rst          (rst),
         .wrStb        (wrStb[i]),
         .regSel       (regSel),
         .wdata        (wdataOut),
         .asClr        (asClr[i]),
         .cardDetect   (cardDetect[i]),
         .writeProtect (writeProtect[i]),
         .ataOut       (ataOut[i]),
         .dsOut        (dsOut[i]),
         .er1Out       (er1Out[i]),
         .daOut        (daOut[i]),
         .dcOut        (dcOut[i]),
         .fncOut       (fncOut[i])
      );
   end

   attnCollect uCollect (
      .driveSel    (driveSel),
      .regSel      (regSel),
      .ataOut      (ataOut),
      .dsOut       (dsOut),
      .er1Out      (er1Out),
      .daOut       (daOut),
      .dcOut       (dcOut),
      .fncOut      (fncOut),
      .rdCandidate (rdCandidate),
      .attn        (attn)
   );

endmodule

`default_nettype wire

/* src/attnCollect.sv */
// Readback multiplexer and attention summary
// Picks the addressed drive's register for the host and ORs the
// attention bits of all drives into one line

`default_nettype none
`timescale 1ns/1ps

module attnCollect (
   input  wire logic [diskPkg::driveSelBits-1:0]                     driveSel,
   input  wire diskPkg::regSel_e                                     regSel,
   input  wire logic [diskPkg::numDrives-1:0]                        ataOut,
   input  wire logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] dsOut,
   input  wire logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] er1Out,
   input  wire logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] daOut,
   input  wire logic [diskPkg::numDrives-1:0][diskPkg::dataWidth-1:0] dcOut,
   input  wire logic [diskPkg::numDrives-1:0][$bits(diskPkg::driveCmd_e)-1:0] fncOut,
   output logic [diskPkg::dataWidth-1:0]                             rdCandidate,
   output logic                                                      attn
);

   // Register readback, unused codes read zero
   always_comb
   begin
      rdCandidate = '0;
      case (regSel)
         diskPkg::regCs1:
            rdCandidate[$bits(diskPkg::driveCmd_e)-1:0] = fncOut[driveSel];
         diskPkg::regDs:
            rdCandidate = dsOut[driveSel];
         diskPkg::regEr1:
            rdCandidate = er1Out[driveSel];
         // AS is shared, one bit per drive
         diskPkg::regAs:
            rdCandidate[diskPkg::numDrives-1:0] = ataOut;
         diskPkg::regDa:
            rdCandidate = daOut[driveSel];
         diskPkg::regDc:
            rdCandidate = dcOut[driveSel];
         default:
            rdCandidate = '0;
      endcase
   end

   // Combined attention line
   assign attn = |ataOut;

endmodule

`default_nettype wire

/* drive/diskDrive.sv */
// One emulated moving-head drive
// Holds the disk address and desired cylinder registers, routes host
// writes to them and to the control block, and builds the status word

`default_nettype none
`timescale 1ns/1ps

module diskDrive (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          wrStb,
   input  wire diskPkg::regSel_e              regSel,
   input  wire logic [diskPkg::dataWidth-1:0] wdata,
   input  wire logic                          asClr,
   input  wire logic                          cardDetect,
   input  wire logic                          writeProtect,
   output logic                               ataOut,
   output logic [diskPkg::dataWidth-1:0]      dsOut,
   output logic [diskPkg::dataWidth-1:0]      er1Out,
   output logic [diskPkg::dataWidth-1:0]      daOut,
   output logic [diskPkg::dataWidth-1:0]      dcOut,
   output logic [$bits(diskPkg::driveCmd_e)-1:0] fncOut
);

   diskPkg::driveState_e state;
   diskPkg::driveCmd_e   cmdCode;

   // Per-register write strobes
   logic cmdStb;
   logic er1WrStb;
   logic daWrStb;
   logic dcWrStb;
   logic isIdle;
   // DA or DC write while busy
   logic refuse;
   // Preset or recal accepted
   logic clrAddr;
   logic er1Stb;
   logic [diskPkg::dataWidth-1:0] er1Wdata;

   assign cmdCode  = diskPkg::driveCmd_e'(wdata[$bits(diskPkg::driveCmd_e)-1:0]);
   assign cmdStb   = wrStb && (regSel == diskPkg::regCs1);
   assign er1WrStb = wrStb && (regSel == diskPkg::regEr1);
   assign daWrStb  = wrStb && (regSel == diskPkg::regDa);
   assign dcWrStb  = wrStb && (regSel == diskPkg::regDc);
   assign isIdle   = (state == diskPkg::stIdle);
   assign refuse   = (daWrStb || dcWrStb) && !isIdle;
   assign clrAddr  = cmdStb && isIdle &&
                     (cmdCode == diskPkg::cmdPreset || cmdCode == diskPkg::cmdRecal);

   // Refusal reaches ER1 as a load of the current value with RMR set
   assign er1Stb = er1WrStb || refuse;
   always_comb
   begin
      er1Wdata = wdata;
      if (refuse)
      begin
         er1Wdata                  = er1Out;
         er1Wdata[diskPkg::er1Rmr] = 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // DA, DC and last function code
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         daOut  <= '0;
         dcOut  <= '0;
         fncOut <= '0;
      end
      else
      begin
         if (clrAddr)
         begin
            daOut <= '0;
            dcOut <= '0;
         end
         else
         begin
            if (daWrStb && isIdle)
               daOut <= wdata;
            if (dcWrStb && isIdle)
               dcOut <= wdata;
         end
         // CS1 readback shows the function last accepted
         if (cmdStb && isIdle)
            fncOut <= wdata[$bits(diskPkg::driveCmd_e)-1:0];
      end
   end

   driveCtrl uCtrl (
      .clk     (clk),
      .rst     (rst),
      .cmdStb  (cmdStb),
      .cmdCode (cmdCode),
      .er1Stb  (er1Stb),
      .wdata   (er1Wdata),
      .dcCyl   (dcOut[diskPkg::dcCylMsb:diskPkg::dcCylLsb]),
      .state   (state),
      .er1     (er1Out)
   );

   driveStatus uStatus (
      .clk          (clk),
      .rst          (rst),
      .state        (state),
      .ataClr       (asClr),
      .cardDetect   (cardDetect),
      .writeProtect (writeProtect),
      .da           (daOut),
      .dc           (dcOut),
      .er1          (er1Out),
      .ataOut       (ataOut),
      .ds           (dsOut)
   );

endmodule

`default_nettype wire

/* drive/driveStatus.sv */
// Drive status word
// Registered attention, volume valid and offset mode flags plus the
// combinational error, positioning, online, lock, last sector and ready bits

`default_nettype none
`timescale 1ns/1ps

module driveStatus (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire diskPkg::driveState_e          state,
   input  wire logic                          ataClr,
   input  wire logic                          cardDetect,
   input  wire logic                          writeProtect,
   input  wire logic [diskPkg::dataWidth-1:0] da,
   input  wire logic [diskPkg::dataWidth-1:0] dc,
   input  wire logic [diskPkg::dataWidth-1:0] er1,
   output logic                               ataOut,
   output logic [diskPkg::dataWidth-1:0]      ds
);

   logic ata;
   logic vv;
   logic om;
   // Heads at the last sector of the pack
   logic lst;

   //////////////////////////////////////////////////////////////////////
   // Registered flags
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ata <= 1'b0;
         vv  <= 1'b0;
         om  <= 1'b0;
      end
      else
      begin
         // Attention, cleared by AS write or drive clear
         if (ataClr || state == diskPkg::stClear)
            ata <= 1'b0;
         else if (state == diskPkg::stAta)
            ata <= 1'b1;

         // Volume valid, lost when the pack goes away
         case (state)
            diskPkg::stIdle:
               vv <= vv & cardDetect;
            diskPkg::stPreset,
            diskPkg::stPakAck:
               vv <= cardDetect;
            default:
               vv <= vv;
         endcase

         // Offset mode
         if (state == diskPkg::stOffset)
            om <= 1'b1;
         else if (state == diskPkg::stReturn)
            om <= 1'b0;
      end
   end

   assign lst = (da[diskPkg::daSecMsb:diskPkg::daSecLsb] == diskPkg::lastSector) &&
                (da[diskPkg::daTrkMsb:diskPkg::daTrkLsb] == diskPkg::lastTrack) &&
                (dc[diskPkg::dcCylMsb:diskPkg::dcCylLsb] == diskPkg::lastCyl);

   assign ataOut = ata;

   // Assemble DS, unlisted bits read zero
   always_comb
   begin
      ds               = '0;
      ds[diskPkg::dsAta] = ata;
      ds[diskPkg::dsErr] = |er1;
      ds[diskPkg::dsPip] = (state == diskPkg::stSeekDly);
      ds[diskPkg::dsMol] = cardDetect;
      ds[diskPkg::dsWrl] = writeProtect;
      ds[diskPkg::dsLst] = lst;
      ds[diskPkg::dsPgm] = 1'b0;
      ds[diskPkg::dsDpr] = 1'b1;
      ds[diskPkg::dsDry] = (state == diskPkg::stIdle);
      ds[diskPkg::dsVv]  = vv;
      ds[diskPkg::dsOm]  = om;
   end

endmodule

`default_nettype wire

/* drive/driveCtrl.sv */
// Drive command state machine
// Dispatches seek, recalibrate, preset, pack acknowledge, offset,
// return and drive clear, times the positioning delay and keeps ER1

`default_nettype none
`timescale 1ns/1ps

module driveCtrl (
   input  wire logic                                          clk,
   input  wire logic                                          rst,
   input  wire logic                                          cmdStb,
   input  wire diskPkg::driveCmd_e                            cmdCode,
   input  wire logic                                          er1Stb,
   input  wire logic [diskPkg::dataWidth-1:0]                 wdata,
   input  wire logic [diskPkg::dcCylMsb:diskPkg::dcCylLsb]    dcCyl,
   output diskPkg::driveState_e                               state,
   output logic [diskPkg::dataWidth-1:0]                      er1
);

   // Positioning down-counter
   logic [diskPkg::seekCntBits-1:0] seekCnt;
   // Seek target past the last cylinder
   logic badCyl;

   assign badCyl = dcCyl > diskPkg::lastCyl;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= diskPkg::stIdle;
         seekCnt <= '0;
         er1     <= '0;
      end
      else
      begin
         // Host load of ER1
         if (er1Stb)
            er1 <= wdata;
         // Command while busy is refused
         if (cmdStb && state != diskPkg::stIdle)
            er1[diskPkg::er1Rmr] <= 1'b1;

         case (state)
            diskPkg::stIdle:
            begin
               if (cmdStb)
               begin
                  case (cmdCode)
                     diskPkg::cmdNop:
                        state <= diskPkg::stIdle;
                     diskPkg::cmdSeek:
                     begin
                        if (badCyl)
                        begin
                           er1[diskPkg::er1Iae] <= 1'b1;
                           state                <= diskPkg::stAta;
                        end
                        else
                        begin
                           seekCnt <= diskPkg::seekLoad;
                           state   <= diskPkg::stSeekDly;
                        end
                     end
                     diskPkg::cmdRecal:
                     begin
                        // Heads back to cylinder zero, same fixed delay
                        seekCnt <= diskPkg::seekLoad;
                        state   <= diskPkg::stSeekDly;
                     end
                     diskPkg::cmdPreset:
                        state <= diskPkg::stPreset;
                     diskPkg::cmdPakAck:
                        state <= diskPkg::stPakAck;
                     diskPkg::cmdOffset:
                        state <= diskPkg::stOffset;
                     diskPkg::cmdReturn:
                        state <= diskPkg::stReturn;
                     diskPkg::cmdDrvClr:
                        state <= diskPkg::stClear;
                     default:
                     begin
                        // Includes read and write, no data path here
                        er1[diskPkg::er1Ilf] <= 1'b1;
                        state                <= diskPkg::stAta;
                     end
                  endcase
               end
            end
            diskPkg::stSeekDly:
            begin
               if (seekCnt == '0)
                  state <= diskPkg::stAta;
               else
                  seekCnt <= seekCnt - 1'b1;
            end
            // Offset and return both finish through attention
            diskPkg::stOffset,
            diskPkg::stReturn:
               state <= diskPkg::stAta;
            diskPkg::stClear:
            begin
               er1   <= '0;
               state <= diskPkg::stIdle;
            end
            // Attention, preset and pack ack all last one cycle
            default:
               state <= diskPkg::stIdle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/regBusDecode.sv */
// Host register port decoder
// Runs the four-phase req/ack handshake, latches the drive and
// register fields and turns a write into a one-cycle strobe

`default_nettype none
`timescale 1ns/1ps

module regBusDecode (
   input  wire logic                                 clk,
   input  wire logic                                 rst,
   input  wire logic                                 req,
   input  wire logic                                 wr,
   input  wire logic [diskPkg::addrWidth-1:0]        addr,
   input  wire logic [diskPkg::dataWidth-1:0]        wdata,
   input  wire logic [diskPkg::dataWidth-1:0]        rdCandidate,
   output logic                                      ack,
   output logic [diskPkg::dataWidth-1:0]             rdata,
   output logic [diskPkg::numDrives-1:0]             wrStb,
   output diskPkg::regSel_e                          regSel,
   output logic [diskPkg::dataWidth-1:0]             wdataOut,
   output logic [diskPkg::numDrives-1:0]             asClr,
   output logic [diskPkg::driveSelBits-1:0]          driveSel
);

   // Access latched, waiting to raise ack
   logic busy;
   logic isWrite;

   //////////////////////////////////////////////////////////////////////
   // Handshake and strobes
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busy     <= 1'b0;
         ack      <= 1'b0;
         isWrite  <= 1'b0;
         wrStb    <= '0;
         asClr    <= '0;
         driveSel <= '0;
         regSel   <= diskPkg::regCs1;
      end
      else
      begin
         // Strobes last one cycle
         wrStb <= '0;
         asClr <= '0;
         if (req && !ack && !busy)
         begin
            // New request, capture the address fields
            busy     <= 1'b1;
            isWrite  <= wr;
            driveSel <= addr[diskPkg::addrWidth-1 -: diskPkg::driveSelBits];
            regSel   <= diskPkg::regSel_e'(addr[$bits(diskPkg::regSel_e)-1:0]);
         end
         else if (busy && !ack)
         begin
            ack <= 1'b1;
            if (isWrite && regSel == diskPkg::regAs)
               // AS write clears attention on every drive with its bit set
               asClr <= wdataOut[diskPkg::numDrives-1:0];
            else if (isWrite)
            begin
               for (int i = 0; i < diskPkg::numDrives; i++)
                  wrStb[i] <= (driveSel == i);
            end
         end
         else if (ack && !req)
         begin
            // Host released req, end of cycle
            ack  <= 1'b0;
            busy <= 1'b0;
         end
      end
   end

   // Write data and read data registers
   always_ff @(posedge clk)
   begin
      if (req && !ack && !busy)
         wdataOut <= wdata;
      if (busy && !ack)
         rdata <= rdCandidate;
   end

endmodule

`default_nettype wire

/* common/diskPkg.sv */
// Disk subsystem shared definitions
// Drive count, pack geometry, host register map, drive function and
// state codes, and the bit positions of the error and status words

`default_nettype none

package diskPkg;

   //////////////////////////////////////////////////////////////////////
   // Subsystem sizes
   //////////////////////////////////////////////////////////////////////

   localparam int numDrives    = 4;
   localparam int driveSelBits = 2;
   localparam int dataWidth    = 16;
   // Drive in addr[4:3], register in addr[2:0]
   localparam int addrWidth    = 5;

   // Highest legal address on the emulated pack
   localparam logic [5:0] lastSector = 6'd19;
   localparam logic [5:0] lastTrack  = 6'd18;
   localparam logic [9:0] lastCyl    = 10'd814;

   // Fixed positioning delay, no real geometry timing
   localparam int seekCycles  = 8;
   localparam int seekCntBits = $clog2(seekCycles);
   localparam logic [seekCntBits-1:0] seekLoad = seekCntBits'(seekCycles - 1);

   //////////////////////////////////////////////////////////////////////
   // Codes
   //////////////////////////////////////////////////////////////////////

   // Host register select, codes 6 and 7 unused
   typedef enum logic [2:0] {
      regCs1 = 3'd0,
      regDs  = 3'd1,
      regEr1 = 3'd2,
      regAs  = 3'd3,
      regDa  = 3'd4,
      regDc  = 3'd5
   } regSel_e;

   // Function code from the low bits of CS1
   // Anything not listed is illegal
   typedef enum logic [3:0] {
      cmdNop    = 4'd0,
      cmdSeek   = 4'd1,
      cmdRecal  = 4'd2,
      cmdPreset = 4'd3,
      cmdPakAck = 4'd4,
      cmdOffset = 4'd5,
      cmdReturn = 4'd6,
      cmdDrvClr = 4'd7
   } driveCmd_e;

   // Per-drive control state
   typedef enum logic [2:0] {
      stIdle    = 3'd0,
      stSeekDly = 3'd1,
      stAta     = 3'd2,
      stClear   = 3'd3,
      stPreset  = 3'd4,
      stPakAck  = 3'd5,
      stOffset  = 3'd6,
      stReturn  = 3'd7
   } driveState_e;

   //////////////////////////////////////////////////////////////////////
   // Bit and field positions
   //////////////////////////////////////////////////////////////////////

   // ER1
   localparam int er1Ilf = 0;
   localparam int er1Rmr = 2;
   localparam int er1Iae = 10;

   // DS
   localparam int dsAta = 15;
   localparam int dsErr = 14;
   localparam int dsPip = 13;
   localparam int dsMol = 12;
   localparam int dsWrl = 11;
   localparam int dsLst = 10;
   localparam int dsPgm = 9;
   localparam int dsDpr = 8;
   localparam int dsDry = 7;
   localparam int dsVv  = 6;
   localparam int dsOm  = 0;

   // DA sector and track, DC cylinder
   localparam int daSecMsb = 5;
   localparam int daSecLsb = 0;
   localparam int daTrkMsb = 13;
   localparam int daTrkLsb = 8;
   localparam int dcCylMsb = 9;
   localparam int dcCylLsb = 0;

endpackage

`default_nettype wire
